// ==== rtl/calc_pkg.sv ====
// Calculator package with shared widths, keypad and operator types, controller states
package calc_pkg;

    // Default operand width for the whole core
    parameter int WIDTH_DEFAULT = 16;

    // One decimal keypad digit, 0 to 9
    typedef logic [3:0] digit_t;

    // One-hot operator code
    typedef logic [2:0] op_code_t;

    localparam op_code_t OP_ADD = 3'b001;
    localparam op_code_t OP_SUB = 3'b010;
    localparam op_code_t OP_MUL = 3'b100;

    // Controller states
    typedef enum logic [3:0] {
        ENTER_A      = 4'd0,
        WAIT_A_SHIFT = 4'd1,
        ADD_A_DIGIT  = 4'd2,
        ENTER_B      = 4'd3,
        WAIT_B_SHIFT = 4'd4,
        ADD_B_DIGIT  = 4'd5,
        DISPATCH     = 4'd6,
        WAIT_RESULT  = 4'd7
    } ctrl_state_t;

endpackage

// ==== rtl/arith_if.sv ====
// Arithmetic unit bus carrying operands, mode and start out, result and finish back
interface arith_if #(
    parameter int WIDTH = calc_pkg::WIDTH_DEFAULT
);

    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    logic             sub;
    logic             start;
    logic [WIDTH-1:0] result;
    logic             finish;

    modport requester (
        output a, b, sub, start,
        input  result, finish
    );

    modport unit (
        input  a, b, sub, start,
        output result, finish
    );

endinterface

// ==== rtl/addsub_unit.sv ====
// Nibble-serial adder/subtractor, one nibble per cycle with a carry flip-flop
module addsub_unit #(
    parameter int WIDTH = calc_pkg::WIDTH_DEFAULT
) (
    input  logic clk,
    input  logic nRST,
    arith_if.unit bus
);

    localparam int NIBBLES = WIDTH / 4;
    localparam int CW      = $clog2(NIBBLES + 1);

    logic             busy;
    logic [CW-1:0]    idx;
    logic             carry;
    logic             finish_q;
    logic [WIDTH-1:0] result_q;

    logic       active;
    logic       cin;
    logic [3:0] a_nib;
    logic [3:0] b_nib;
    logic [4:0] nib_sum;

    // Operands stay stable on the bus until finish, so read them in place
    assign active  = bus.start || busy;
    assign cin     = bus.start ? bus.sub : carry;
    assign a_nib   = bus.a[idx*4 +: 4];
    assign b_nib   = bus.sub ? ~bus.b[idx*4 +: 4] : bus.b[idx*4 +: 4];
    assign nib_sum = {1'b0, a_nib} + {1'b0, b_nib} + {4'd0, cin};

    assign bus.result = result_q;
    assign bus.finish = finish_q;

    always_ff @(posedge clk) begin
        if (active)
            result_q[idx*4 +: 4] <= nib_sum[3:0];
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy     <= 1'b0;
            idx      <= '0;
            carry    <= 1'b0;
            finish_q <= 1'b0;
        end else begin
            finish_q <= 1'b0;
            if (active) begin
                carry <= nib_sum[4];
                if (idx == CW'(NIBBLES - 1)) begin
                    busy     <= 1'b0;
                    idx      <= '0;
                    finish_q <= 1'b1;
                end else begin
                    busy <= 1'b1;
                    idx  <= idx + 1'b1;
                end
            end
        end
    end

endmodule

// ==== rtl/shift_add_mult.sv ====
// Shift-and-add multiplier keeping the low WIDTH bits, one multiplier bit per cycle
module shift_add_mult #(
    parameter int WIDTH = calc_pkg::WIDTH_DEFAULT
) (
    input  logic clk,
    input  logic nRST,
    arith_if.unit bus
);

    localparam int CW = $clog2(WIDTH + 1);

    logic             busy;
    logic [CW-1:0]    cnt;
    logic             finish_q;
    logic [WIDTH-1:0] prod_q;
    logic [WIDTH-1:0] mcand_q;
    logic [WIDTH-1:0] mplier_q;

    logic             active;
    logic             mbit;
    logic [WIDTH-1:0] addend;
    logic [WIDTH-1:0] base;
    logic [WIDTH-1:0] mplier;

    // First iteration works straight off the bus
    assign active = bus.start || busy;
    assign addend = bus.start ? bus.a : mcand_q;
    assign mplier = bus.start ? bus.b : mplier_q;
    assign base   = bus.start ? '0 : prod_q;
    assign mbit   = mplier[0];

    assign bus.result = prod_q;
    assign bus.finish = finish_q;

    always_ff @(posedge clk) begin
        if (active) begin
            prod_q   <= base + (mbit ? addend : '0);
            mcand_q  <= addend << 1;
            mplier_q <= mplier >> 1;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy     <= 1'b0;
            cnt      <= '0;
            finish_q <= 1'b0;
        end else begin
            finish_q <= 1'b0;
            if (active) begin
                if (cnt == CW'(WIDTH - 1)) begin
                    busy     <= 1'b0;
                    cnt      <= '0;
                    finish_q <= 1'b1;
                end else begin
                    busy <= 1'b1;
                    cnt  <= cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== rtl/result_reg.sv ====
// Result register holding the displayed value and pulsing complete once per result
module result_reg #(
    parameter int WIDTH = calc_pkg::WIDTH_DEFAULT
) (
    input  logic             clk,
    input  logic             nRST,

    input  logic [WIDTH-1:0] sum,
    input  logic [WIDTH-1:0] product,
    input  logic             take_sum,
    input  logic             take_product,
    input  logic             clear,

    output logic             complete,
    output logic [WIDTH-1:0] display_output
);

    logic             take;
    logic             shown;
    logic [WIDTH-1:0] chosen;

    assign take   = take_sum || take_product;
    assign chosen = take_product ? product : sum;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            complete       <= 1'b0;
            shown          <= 1'b0;
            display_output <= '0;
        end else begin
            complete <= take && !shown;
            if (take) begin
                display_output <= chosen;
                shown          <= 1'b1;
            end else if (clear) begin
                // Display keeps the old value
                shown <= 1'b0;
            end
        end
    end

endmodule

// ==== rtl/calc_ctrl.sv ====
// Calculator controller FSM building decimal operands and dispatching the operation
module calc_ctrl #(
    parameter int WIDTH = calc_pkg::WIDTH_DEFAULT
) (
    input  logic               clk,
    input  logic               nRST,

    input  calc_pkg::digit_t   keypad_input,
    input  logic               read_input,
    input  calc_pkg::op_code_t operator_input,
    input  logic               equal_input,

    arith_if.requester         as_bus,
    arith_if.requester         mul_bus,

    output logic               clear,
    output logic               take_sum,
    output logic               take_product
);

    localparam logic [WIDTH-1:0] TEN = WIDTH'(10);

    calc_pkg::ctrl_state_t state, next_state;

    logic [WIDTH-1:0]   operand_a;
    logic [WIDTH-1:0]   operand_b;
    calc_pkg::digit_t   digit;
    calc_pkg::op_code_t op_code;
    logic               a_empty;

    logic             digit_start;
    logic             op_legal;
    logic             is_mul;
    logic             b_entry;
    logic             calc_phase;
    logic             unit_done;
    logic [WIDTH-1:0] digit_ext;

    assign op_legal = (operator_input == calc_pkg::OP_ADD) ||
                      (operator_input == calc_pkg::OP_SUB) ||
                      (operator_input == calc_pkg::OP_MUL);

    assign is_mul     = (op_code == calc_pkg::OP_MUL);
    assign b_entry    = (state == calc_pkg::ENTER_B) || (state == calc_pkg::WAIT_B_SHIFT);
    assign calc_phase = (state == calc_pkg::DISPATCH) || (state == calc_pkg::WAIT_RESULT);
    assign digit_ext  = WIDTH'(digit);
    assign unit_done  = is_mul ? mul_bus.finish : as_bus.finish;

    assign digit_start = read_input &&
                         ((state == calc_pkg::ENTER_A) || (state == calc_pkg::ENTER_B));

    // Multiplier does both the times-ten step and the real multiply
    assign mul_bus.a     = b_entry ? operand_b : operand_a;
    assign mul_bus.b     = calc_phase ? operand_b : TEN;
    assign mul_bus.start = digit_start || ((state == calc_pkg::DISPATCH) && is_mul);

    assign as_bus.a     = operand_a;
    assign as_bus.b     = operand_b;
    assign as_bus.sub   = (op_code == calc_pkg::OP_SUB);
    assign as_bus.start = (state == calc_pkg::DISPATCH) && !is_mul;

    always_comb begin
        next_state = state;
        case (state)
            calc_pkg::ENTER_A: begin
                if (read_input)
                    next_state = calc_pkg::WAIT_A_SHIFT;
                else if (op_legal)
                    next_state = calc_pkg::ENTER_B;
            end
            calc_pkg::WAIT_A_SHIFT: begin
                if (mul_bus.finish)
                    next_state = calc_pkg::ADD_A_DIGIT;
            end
            calc_pkg::ADD_A_DIGIT:
                next_state = calc_pkg::ENTER_A;
            calc_pkg::ENTER_B: begin
                if (read_input)
                    next_state = calc_pkg::WAIT_B_SHIFT;
                else if (equal_input)
                    next_state = calc_pkg::DISPATCH;
            end
            calc_pkg::WAIT_B_SHIFT: begin
                if (mul_bus.finish)
                    next_state = calc_pkg::ADD_B_DIGIT;
            end
            calc_pkg::ADD_B_DIGIT:
                next_state = calc_pkg::ENTER_B;
            calc_pkg::DISPATCH:
                next_state = calc_pkg::WAIT_RESULT;
            calc_pkg::WAIT_RESULT: begin
                if (unit_done)
                    next_state = calc_pkg::ENTER_A;
            end
            default:
                next_state = calc_pkg::ENTER_A;
        endcase
    end

    always_ff @(posedge clk) begin
        if (digit_start)
            digit <= keypad_input;
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state        <= calc_pkg::ENTER_A;
            operand_a    <= '0;
            operand_b    <= '0;
            op_code      <= '0;
            a_empty      <= 1'b1;
            clear        <= 1'b0;
            take_sum     <= 1'b0;
            take_product <= 1'b0;
        end else begin
            state        <= next_state;
            clear        <= 1'b0;
            take_sum     <= 1'b0;
            take_product <= 1'b0;

            case (state)
                calc_pkg::ENTER_A: begin
                    // First key of a new calculation
                    if ((read_input || op_legal) && a_empty) begin
                        clear   <= 1'b1;
                        a_empty <= 1'b0;
                    end
                    if (!read_input && op_legal)
                        op_code <= operator_input;
                end
                calc_pkg::WAIT_A_SHIFT: begin
                    if (mul_bus.finish)
                        operand_a <= mul_bus.result;
                end
                calc_pkg::ADD_A_DIGIT:
                    operand_a <= operand_a + digit_ext;
                calc_pkg::WAIT_B_SHIFT: begin
                    if (mul_bus.finish)
                        operand_b <= mul_bus.result;
                end
                calc_pkg::ADD_B_DIGIT:
                    operand_b <= operand_b + digit_ext;
                calc_pkg::WAIT_RESULT: begin
                    if (unit_done) begin
                        take_sum     <= !is_mul;
                        take_product <= is_mul;
                        operand_a    <= '0;
                        operand_b    <= '0;
                        a_empty      <= 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== rtl/calc_top.sv ====
// Calculator core top joining controller, add/subtract unit, multiplier and result register
module calc_top #(
    parameter int WIDTH = calc_pkg::WIDTH_DEFAULT
) (
    input  logic              clk,
    input  logic              nRST,

    input  calc_pkg::digit_t   keypad_input,
    input  logic              read_input,
    input  calc_pkg::op_code_t operator_input,
    input  logic              equal_input,

    output logic              complete,
    output logic [WIDTH-1:0]  display_output
);

    logic clear;
    logic take_sum;
    logic take_product;

    arith_if #(.WIDTH(WIDTH)) as_bus ();
    arith_if #(.WIDTH(WIDTH)) mul_bus ();

    // Multiplier has no mode
    assign mul_bus.sub = 1'b0;

    calc_ctrl #(.WIDTH(WIDTH)) ctrl0 (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .as_bus         (as_bus.requester),
        .mul_bus        (mul_bus.requester),
        .clear          (clear),
        .take_sum       (take_sum),
        .take_product   (take_product)
    );

    addsub_unit #(.WIDTH(WIDTH)) addsub0 (
        .clk  (clk),
        .nRST (nRST),
        .bus  (as_bus.unit)
    );

    shift_add_mult #(.WIDTH(WIDTH)) mult0 (
        .clk  (clk),
        .nRST (nRST),
        .bus  (mul_bus.unit)
    );

    result_reg #(.WIDTH(WIDTH)) result0 (
        .clk            (clk),
        .nRST           (nRST),
        .sum            (as_bus.result),
        .product        (mul_bus.result),
        .take_sum       (take_sum),
        .take_product   (take_product),
        .clear          (clear),
        .complete       (complete),
        .display_output (display_output)
    );

endmodule

// ==== bench/calc_checker.sv ====
// Calculator checker modelling key entry and comparing every displayed result
module calc_checker #(
    parameter int WIDTH = calc_pkg::WIDTH_DEFAULT
) (
    input logic               clk,
    input logic               nRST,
    input calc_pkg::digit_t   keypad_input,
    input logic               read_input,
    input calc_pkg::op_code_t operator_input,
    input logic               equal_input,
    input logic               complete,
    input logic [WIDTH-1:0]   display_output
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [WIDTH-1:0]   model_a;
    logic [WIDTH-1:0]   model_b;
    logic [WIDTH-1:0]   model_result;
    logic [WIDTH-1:0]   expected;
    logic [WIDTH-1:0]   shown;
    calc_pkg::op_code_t model_op;
    bit                 in_b;
    logic [WIDTH-1:0]   pending[$];
    int                 mismatch_count = 0;
    int                 fault_count = 0;
    int                 results_checked = 0;

    function automatic bit legal_op(input calc_pkg::op_code_t code);
        return (code == calc_pkg::OP_ADD) || (code == calc_pkg::OP_SUB) ||
               (code == calc_pkg::OP_MUL);
    endfunction

    always @(posedge clk) begin
        if (!nRST) begin
            model_a  = '0;
            model_b  = '0;
            model_op = '0;
            in_b     = 1'b0;
            shown    = '0;
            pending.delete();
        end else begin
            if (complete) begin
                if (pending.size() == 0) begin
                    $display("ERROR: complete pulsed with no calculation pending at %0t", $time);
                    fault_count++;
                end else begin
                    expected = pending.pop_front();
                    results_checked++;
                    if (display_output !== expected) begin
                        $display("MISMATCH display_output expected %h got %h at %0t",
                                 expected, display_output, $time);
                        mismatch_count++;
                    end
                end
                shown = display_output;
            end else if (display_output !== shown) begin
                // Display must hold between results
                $display("MISMATCH display_output expected %h got %h at %0t (held value)",
                         shown, display_output, $time);
                mismatch_count++;
                shown = display_output;
            end

            if (read_input) begin
                if (in_b)
                    model_b = WIDTH'(model_b * 10 + keypad_input);
                else
                    model_a = WIDTH'(model_a * 10 + keypad_input);
            end else if (!in_b && legal_op(operator_input)) begin
                model_op = operator_input;
                in_b     = 1'b1;
            end else if (in_b && equal_input) begin
                case (model_op)
                    calc_pkg::OP_ADD: model_result = WIDTH'(model_a + model_b);
                    calc_pkg::OP_SUB: model_result = WIDTH'(model_a - model_b);
                    default:          model_result = WIDTH'(model_a * model_b);
                endcase
                pending.push_back(model_result);
                model_a = '0;
                model_b = '0;
                in_b    = 1'b0;
            end
        end
    end

    task automatic close_report(input int calcs_issued);
        if (pending.size() != 0) begin
            $display("ERROR: %0d results were never shown", pending.size());
            fault_count++;
        end
        if (results_checked != calcs_issued) begin
            $display("ERROR: %0d results shown for %0d calculations", results_checked,
                     calcs_issued);
            fault_count++;
        end
        $display("checker: %0d results checked, %0d mismatches, %0d other errors",
                 results_checked, mismatch_count, fault_count);
    endtask

    function automatic int error_total();
        return mismatch_count + fault_count;
    endfunction

endmodule

// ==== bench/tb_calc.sv ====
// Calculator core testbench driving random key sequences into the DUT
module tb_calc;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WIDTH       = 16;
    localparam int N_CALCS     = 200;
    localparam int GAP         = 24;
    localparam int MAX_STROBES = 14;
    localparam int TIMEOUT     = N_CALCS * (MAX_STROBES * GAP + 40) + 2000;

    logic               clk;
    logic               nRST;
    calc_pkg::digit_t   keypad_input;
    logic               read_input;
    calc_pkg::op_code_t operator_input;
    logic               equal_input;
    logic               complete;
    logic [WIDTH-1:0]   display_output;

    integer seed;

    calc_top #(.WIDTH(WIDTH)) dut0 (.*);

    calc_checker #(.WIDTH(WIDTH)) checker0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Sized for the longest key sequence of every calculation
    initial begin
        repeat (TIMEOUT) @(posedge clk);
        $display("timeout: complete never arrived");
        $display("Checks failed");
        $finish;
    end

    function automatic int rand_below(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    // Single-cycle strobe, optionally followed by the idle gap
    task automatic strobe(input logic rd, input logic eq, input calc_pkg::digit_t key,
                          input calc_pkg::op_code_t op, input bit leave_gap);
        @(posedge clk);
        #10;
        keypad_input   = key;
        read_input     = rd;
        equal_input    = eq;
        operator_input = op;
        @(posedge clk);
        #10;
        read_input     = 1'b0;
        equal_input    = 1'b0;
        operator_input = '0;
        if (leave_gap)
            repeat (GAP - 2) @(posedge clk);
    endtask

    task automatic wait_for_complete();
        do
            @(posedge clk);
        while (!complete);
    endtask

    task automatic run_calculation();
        int                 a_digits;
        int                 b_digits;
        int                 stray_at;
        int                 r;
        calc_pkg::op_code_t op;
        a_digits = 1 + rand_below(5);
        b_digits = 1 + rand_below(5);
        stray_at = rand_below(10);
        for (int i = 0; i < a_digits; i++) begin
            strobe(1'b1, 1'b0, calc_pkg::digit_t'(rand_below(10)), '0, 1'b1);
            // Equal while still on the first operand
            if (i == stray_at)
                strobe(1'b0, 1'b1, '0, '0, 1'b1);
        end
        if (rand_below(4) == 0) begin
            // Codes 3, 5, 6, 7
            r  = rand_below(4);
            op = calc_pkg::op_code_t'(r + 3 + ((r > 0) ? 1 : 0));
            strobe(1'b0, 1'b0, '0, op, 1'b1);
        end
        case (rand_below(3))
            0:       op = calc_pkg::OP_ADD;
            1:       op = calc_pkg::OP_SUB;
            default: op = calc_pkg::OP_MUL;
        endcase
        strobe(1'b0, 1'b0, '0, op, 1'b1);
        for (int i = 0; i < b_digits; i++)
            strobe(1'b1, 1'b0, calc_pkg::digit_t'(rand_below(10)), '0, 1'b1);
        strobe(1'b0, 1'b1, '0, '0, 1'b0);
        wait_for_complete();
        repeat (2) @(posedge clk);
    endtask

    initial begin
        seed           = 32'h7291_2f39;
        nRST           = 1'b0;
        keypad_input   = '0;
        read_input     = 1'b0;
        operator_input = '0;
        equal_input    = 1'b0;
        repeat (4) @(posedge clk);
        #10;
        nRST = 1'b1;
        repeat (4) @(posedge clk);
        for (int n = 0; n < N_CALCS; n++)
            run_calculation();
        repeat (GAP) @(posedge clk);
        checker0.close_report(N_CALCS);
        if (checker0.error_total() == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// ==== sources.f ====
rtl/calc_pkg.sv
rtl/arith_if.sv
rtl/addsub_unit.sv
rtl/shift_add_mult.sv
rtl/result_reg.sv
rtl/calc_ctrl.sv
rtl/calc_top.sv
bench/calc_checker.sv
bench/tb_calc.sv
